// File: hdl/rsPkg.sv
package rsPkg;

    localparam int dataWidth = 32;
    localparam int nameWidth = 5;
    localparam int opWidth = 4;
    localparam int rsSize = 8;
    localparam int slotWidth = 3;
    localparam int unitWidth = 2;
    localparam int tagWidth = unitWidth + slotWidth;

    // producer units encoded in the upper tag bits
    localparam logic [unitWidth-1:0] unitNone = 2'd0;
    localparam logic [unitWidth-1:0] unitAlu = 2'd1;
    localparam logic [unitWidth-1:0] unitLs = 2'd2;

    // operand already holds a value
    localparam logic [tagWidth-1:0] tagFree = {unitNone, {slotWidth{1'b0}}};
    localparam logic [dataWidth-1:0] dataFree = '0;
    localparam logic [nameWidth-1:0] nameFree = '0;

    localparam logic [opWidth-1:0] opNop = 4'd0;
    localparam logic [opWidth-1:0] opAdd = 4'd1;
    localparam logic [opWidth-1:0] opSub = 4'd2;
    localparam logic [opWidth-1:0] opAnd = 4'd3;
    localparam logic [opWidth-1:0] opOr = 4'd4;
    localparam logic [opWidth-1:0] opXor = 4'd5;
    localparam logic [opWidth-1:0] opSll = 4'd6;
    localparam logic [opWidth-1:0] opSrl = 4'd7;
    localparam logic [opWidth-1:0] opSlt = 4'd8;
    // operand one plus immediate, immediate is pc or offset
    localparam logic [opWidth-1:0] opAddImm = 4'd9;

    typedef struct packed {
        logic [unitWidth-1:0] unit;
        logic [slotWidth-1:0] slot;
    } rsTagFields_s;

    // raw for tag compares, fields for slot decode and tag building
    typedef union packed {
        logic [tagWidth-1:0] raw;
        rsTagFields_s fields;
    } rsTag_u;

endpackage

// File: hdl/rsEntry.sv
`timescale 1ns/1ns

module rsEntry (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          aluValid,
    input  rsPkg::rsTag_u                 aluTag,
    input  logic [rsPkg::dataWidth-1:0]   aluData,
    input  logic                          lsValid,
    input  rsPkg::rsTag_u                 lsTag,
    input  logic [rsPkg::dataWidth-1:0]   lsData,
    input  logic                          allocEn,
    input  logic [rsPkg::dataWidth-1:0]   allocOperandO,
    input  logic [rsPkg::dataWidth-1:0]   allocOperandT,
    input  rsPkg::rsTag_u                 allocTagO,
    input  rsPkg::rsTag_u                 allocTagT,
    input  rsPkg::rsTag_u                 allocTagW,
    input  logic [rsPkg::nameWidth-1:0]   allocName,
    input  logic [rsPkg::opWidth-1:0]     allocOp,
    input  logic [rsPkg::dataWidth-1:0]   allocImm,
    input  logic                          occupied,
    output logic                          ready,
    output logic [rsPkg::dataWidth-1:0]   issueOperandO,
    output logic [rsPkg::dataWidth-1:0]   issueOperandT,
    output logic [rsPkg::opWidth-1:0]     issueOp,
    output logic [rsPkg::nameWidth-1:0]   issueName,
    output logic [rsPkg::dataWidth-1:0]   issueImm
);

    rsPkg::rsTag_u tagO;
    rsPkg::rsTag_u tagT;
    logic [rsPkg::dataWidth-1:0] dataO;
    logic [rsPkg::dataWidth-1:0] dataT;
    logic [rsPkg::opWidth-1:0] opReg;
    logic [rsPkg::nameWidth-1:0] nameReg;
    logic [rsPkg::dataWidth-1:0] immReg;

    logic load;
    rsPkg::rsTag_u srcTagO;
    rsPkg::rsTag_u srcTagT;
    logic [rsPkg::dataWidth-1:0] srcDataO;
    logic [rsPkg::dataWidth-1:0] srcDataT;
    logic [1:0] hitO;
    logic [1:0] hitT;
    rsPkg::rsTag_u nextTagO;
    rsPkg::rsTag_u nextTagT;
    logic [rsPkg::dataWidth-1:0] nextDataO;
    logic [rsPkg::dataWidth-1:0] nextDataT;

    // {alu hit, ls hit} for one operand tag
    function automatic logic [1:0] matchBroadcast(input rsPkg::rsTag_u tag);
        logic aluHit;
        logic lsHit;
        aluHit = aluValid && (tag.raw == aluTag.raw);
        lsHit = lsValid && (tag.raw == lsTag.raw);
        return {aluHit, lsHit};
    endfunction

    // only ALU destination tags belong in this station
    assign load = allocEn && (allocTagW.fields.unit == rsPkg::unitAlu);

    // a broadcast in the allocation cycle is caught on the incoming operands
    assign srcTagO = load ? allocTagO : tagO;
    assign srcTagT = load ? allocTagT : tagT;
    assign srcDataO = load ? allocOperandO : dataO;
    assign srcDataT = load ? allocOperandT : dataT;

    assign hitO = matchBroadcast(srcTagO);
    assign hitT = matchBroadcast(srcTagT);

    // alu broadcast wins over load/store
    assign nextTagO = (|hitO) ? rsPkg::tagFree : srcTagO.raw;
    assign nextTagT = (|hitT) ? rsPkg::tagFree : srcTagT.raw;
    assign nextDataO = hitO[1] ? aluData : (hitO[0] ? lsData : srcDataO);
    assign nextDataT = hitT[1] ? aluData : (hitT[0] ? lsData : srcDataT);

    assign ready = occupied && (nextTagO.raw == rsPkg::tagFree)
                   && (nextTagT.raw == rsPkg::tagFree);
    assign issueOperandO = nextDataO;
    assign issueOperandT = nextDataT;
    assign issueOp = opReg;
    assign issueName = nameReg;
    assign issueImm = immReg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagO <= rsPkg::tagFree;
            tagT <= rsPkg::tagFree;
        end else begin
            tagO <= nextTagO;
            tagT <= nextTagT;
        end
    end

    always_ff @(posedge clk) begin
        dataO <= nextDataO;
        dataT <= nextDataT;
        if (load) begin
            opReg <= allocOp;
            nameReg <= allocName;
            immReg <= allocImm;
        end
    end

endmodule

// File: hdl/aluRsCtrl.sv
`timescale 1ns/1ns

module aluRsCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          allocEn,
    input  rsPkg::rsTag_u                 allocTagW,
    input  logic [rsPkg::rsSize-1:0]      ready,
    input  logic [rsPkg::dataWidth-1:0]   entryOperandO [rsPkg::rsSize],
    input  logic [rsPkg::dataWidth-1:0]   entryOperandT [rsPkg::rsSize],
    input  logic [rsPkg::opWidth-1:0]     entryOp [rsPkg::rsSize],
    input  logic [rsPkg::nameWidth-1:0]   entryName [rsPkg::rsSize],
    input  logic [rsPkg::dataWidth-1:0]   entryImm [rsPkg::rsSize],
    output logic [rsPkg::rsSize-1:0]      slotAlloc,
    output logic [rsPkg::rsSize-1:0]      occupied,
    output logic                          issueValid,
    output logic [rsPkg::dataWidth-1:0]   issueOperandO,
    output logic [rsPkg::dataWidth-1:0]   issueOperandT,
    output logic [rsPkg::opWidth-1:0]     issueOp,
    output logic [rsPkg::nameWidth-1:0]   issueName,
    output logic [rsPkg::dataWidth-1:0]   issueImm,
    output rsPkg::rsTag_u                 issueTag,
    output logic                          full
);

    logic [rsPkg::rsSize-1:0] grant;
    logic [rsPkg::slotWidth-1:0] grantSlot;
    logic grantAny;
    rsPkg::rsTag_u grantTag;

    // one-hot decode of the destination slot
    always_comb begin
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            slotAlloc[i] = allocEn
                           && (allocTagW.fields.unit == rsPkg::unitAlu)
                           && (allocTagW.fields.slot == rsPkg::slotWidth'(i));
        end
    end

    // lowest ready slot
    assign grant = ready & (~ready + 1'b1);
    assign grantAny = |ready;

    always_comb begin
        grantSlot = '0;
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            if (grant[i]) begin
                grantSlot = rsPkg::slotWidth'(i);
            end
        end
    end

    always_comb begin
        grantTag.fields.unit = rsPkg::unitAlu;
        grantTag.fields.slot = grantSlot;
    end

    // issued slot frees, allocated slot fills
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied & ~grant) | slotAlloc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issueValid <= 1'b0;
            issueTag <= rsPkg::tagFree;
        end else begin
            issueValid <= grantAny;
            if (grantAny) begin
                issueTag <= grantTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantAny) begin
            issueOperandO <= entryOperandO[grantSlot];
            issueOperandT <= entryOperandT[grantSlot];
            issueOp <= entryOp[grantSlot];
            issueName <= entryName[grantSlot];
            issueImm <= entryImm[grantSlot];
        end
    end

    assign full = &occupied;

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issueValid,
    input  logic [rsPkg::dataWidth-1:0]   issueOperandO,
    input  logic [rsPkg::dataWidth-1:0]   issueOperandT,
    input  logic [rsPkg::opWidth-1:0]     issueOp,
    input  logic [rsPkg::nameWidth-1:0]   issueName,
    input  logic [rsPkg::dataWidth-1:0]   issueImm,
    input  rsPkg::rsTag_u                 issueTag,
    output logic                          resultValid,
    output rsPkg::rsTag_u                 resultTag,
    output logic [rsPkg::nameWidth-1:0]   resultName,
    output logic [rsPkg::dataWidth-1:0]   resultData
);

    logic [4:0] shamt;
    logic [rsPkg::dataWidth-1:0] aluOut;

    // shift amount from the low bits of operand two
    assign shamt = issueOperandT[4:0];

    always_comb begin
        case (issueOp)
            rsPkg::opAdd: aluOut = issueOperandO + issueOperandT;
            rsPkg::opSub: aluOut = issueOperandO - issueOperandT;
            rsPkg::opAnd: aluOut = issueOperandO & issueOperandT;
            rsPkg::opOr: aluOut = issueOperandO | issueOperandT;
            rsPkg::opXor: aluOut = issueOperandO ^ issueOperandT;
            rsPkg::opSll: aluOut = issueOperandO << shamt;
            rsPkg::opSrl: aluOut = issueOperandO >> shamt;
            rsPkg::opSlt: begin
                aluOut = ($signed(issueOperandO) < $signed(issueOperandT))
                         ? rsPkg::dataWidth'(1) : rsPkg::dataFree;
            end
            rsPkg::opAddImm: aluOut = issueOperandO + issueImm;
            default: aluOut = rsPkg::dataFree;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
            resultTag <= rsPkg::tagFree;
            resultName <= rsPkg::nameFree;
        end else begin
            resultValid <= issueValid;
            if (issueValid) begin
                resultTag <= issueTag;
                resultName <= issueName;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            resultData <= aluOut;
        end
    end

endmodule

// File: hdl/aluRsTop.sv
`timescale 1ns/1ns

module aluRsTop (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          allocEn,
    input  logic [rsPkg::dataWidth-1:0]   allocOperandO,
    input  logic [rsPkg::dataWidth-1:0]   allocOperandT,
    input  rsPkg::rsTag_u                 allocTagO,
    input  rsPkg::rsTag_u                 allocTagT,
    input  rsPkg::rsTag_u                 allocTagW,
    input  logic [rsPkg::nameWidth-1:0]   allocName,
    input  logic [rsPkg::opWidth-1:0]     allocOp,
    input  logic [rsPkg::dataWidth-1:0]   allocImm,
    input  logic                          lsValid,
    input  rsPkg::rsTag_u                 lsTag,
    input  logic [rsPkg::dataWidth-1:0]   lsData,
    output logic                          full,
    output logic                          resultValid,
    output rsPkg::rsTag_u                 resultTag,
    output logic [rsPkg::nameWidth-1:0]   resultName,
    output logic [rsPkg::dataWidth-1:0]   resultData
);

    logic [rsPkg::rsSize-1:0] slotAlloc;
    logic [rsPkg::rsSize-1:0] occupied;
    logic [rsPkg::rsSize-1:0] ready;
    logic [rsPkg::dataWidth-1:0] entryOperandO [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] entryOperandT [rsPkg::rsSize];
    logic [rsPkg::opWidth-1:0] entryOp [rsPkg::rsSize];
    logic [rsPkg::nameWidth-1:0] entryName [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] entryImm [rsPkg::rsSize];

    logic issueValid;
    logic [rsPkg::dataWidth-1:0] issueOperandO;
    logic [rsPkg::dataWidth-1:0] issueOperandT;
    logic [rsPkg::opWidth-1:0] issueOp;
    logic [rsPkg::nameWidth-1:0] issueName;
    logic [rsPkg::dataWidth-1:0] issueImm;
    rsPkg::rsTag_u issueTag;

    aluRsCtrl ctrl (
        .clk(clk),
        .rst(rst),
        .allocEn(allocEn),
        .allocTagW(allocTagW),
        .ready(ready),
        .entryOperandO(entryOperandO),
        .entryOperandT(entryOperandT),
        .entryOp(entryOp),
        .entryName(entryName),
        .entryImm(entryImm),
        .slotAlloc(slotAlloc),
        .occupied(occupied),
        .issueValid(issueValid),
        .issueOperandO(issueOperandO),
        .issueOperandT(issueOperandT),
        .issueOp(issueOp),
        .issueName(issueName),
        .issueImm(issueImm),
        .issueTag(issueTag),
        .full(full)
    );

    // alu result fed back as second capture source
    for (genvar s = 0; s < rsPkg::rsSize; s++) begin : gEntry
        rsEntry entry (
            .clk(clk),
            .rst(rst),
            .aluValid(resultValid),
            .aluTag(resultTag),
            .aluData(resultData),
            .lsValid(lsValid),
            .lsTag(lsTag),
            .lsData(lsData),
            .allocEn(slotAlloc[s]),
            .allocOperandO(allocOperandO),
            .allocOperandT(allocOperandT),
            .allocTagO(allocTagO),
            .allocTagT(allocTagT),
            .allocTagW(allocTagW),
            .allocName(allocName),
            .allocOp(allocOp),
            .allocImm(allocImm),
            .occupied(occupied[s]),
            .ready(ready[s]),
            .issueOperandO(entryOperandO[s]),
            .issueOperandT(entryOperandT[s]),
            .issueOp(entryOp[s]),
            .issueName(entryName[s]),
            .issueImm(entryImm[s])
        );
    end

    aluUnit alu (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueOperandO(issueOperandO),
        .issueOperandT(issueOperandT),
        .issueOp(issueOp),
        .issueName(issueName),
        .issueImm(issueImm),
        .issueTag(issueTag),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .resultName(resultName),
        .resultData(resultData)
    );

endmodule

// File: verification/aluRsProperties.sv
`timescale 1ns/1ns

module aluRsProperties (
    input logic                     clk,
    input logic                     rst,
    input logic [rsPkg::rsSize-1:0] grant,
    input logic [rsPkg::rsSize-1:0] slotAlloc,
    input logic [rsPkg::rsSize-1:0] occupied,
    input logic                     issueValid,
    input logic                     full
);

    int failCount = 0;

    // issue register is loaded only from an occupied slot
    issueFromOccupied: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> $past(|(grant & occupied)))
    else begin
        failCount++;
        $error("issue came from an unoccupied slot");
    end

    allocIntoFree: assert property (@(posedge clk) disable iff (rst)
        (slotAlloc & occupied) == '0)
    else begin
        failCount++;
        $error("allocation targets an occupied slot");
    end

    fullAfterReset: assert property (@(posedge clk) $fell(rst) |-> !full)
    else begin
        failCount++;
        $error("full is high after reset");
    end

endmodule

bind aluRsCtrl aluRsProperties props (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .slotAlloc(slotAlloc),
    .occupied(occupied),
    .issueValid(issueValid),
    .full(full)
);

// File: verification/aluRsRef.svh
`ifndef ALU_RS_REF_SVH
`define ALU_RS_REF_SVH

// expected ALU result from op code, both operands and immediate
function automatic logic [31:0] aluRef(input logic [3:0] op,
                                       input logic [31:0] a,
                                       input logic [31:0] b,
                                       input logic [31:0] imm);
    logic [31:0] r;
    case (op)
        rsPkg::opAdd: r = a + b;
        rsPkg::opSub: r = a - b;
        rsPkg::opAnd: r = a & b;
        rsPkg::opOr: r = a | b;
        rsPkg::opXor: r = a ^ b;
        // shift amount is the low five bits of operand two
        rsPkg::opSll: r = a << b[4:0];
        rsPkg::opSrl: r = a >> b[4:0];
        rsPkg::opSlt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rsPkg::opAddImm: r = a + imm;
        default: r = 32'd0;
    endcase
    return r;
endfunction

`endif

// File: verification/aluRsTb.sv
`timescale 1ns/1ns

module aluRsTb;

    logic clk = 1'b0;
    logic rst;
    logic allocEn;
    logic [rsPkg::dataWidth-1:0] allocOperandO;
    logic [rsPkg::dataWidth-1:0] allocOperandT;
    rsPkg::rsTag_u allocTagO;
    rsPkg::rsTag_u allocTagT;
    rsPkg::rsTag_u allocTagW;
    logic [rsPkg::nameWidth-1:0] allocName;
    logic [rsPkg::opWidth-1:0] allocOp;
    logic [rsPkg::dataWidth-1:0] allocImm;
    logic lsValid;
    rsPkg::rsTag_u lsTag;
    logic [rsPkg::dataWidth-1:0] lsData;
    logic full;
    logic resultValid;
    rsPkg::rsTag_u resultTag;
    logic [rsPkg::nameWidth-1:0] resultName;
    logic [rsPkg::dataWidth-1:0] resultData;

    int seed = 84;
    int cycleCount = 0;

    // per-slot expected record, busy until its result is seen
    bit busy [rsPkg::rsSize];
    logic [rsPkg::opWidth-1:0] expOp [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] valO [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] valT [rsPkg::rsSize];
    logic [rsPkg::tagWidth-1:0] waitO [rsPkg::rsSize];
    logic [rsPkg::tagWidth-1:0] waitT [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] expImm [rsPkg::rsSize];
    logic [rsPkg::nameWidth-1:0] expName [rsPkg::rsSize];
    int allocCycle [rsPkg::rsSize];
    int latency [rsPkg::rsSize];
    // outstanding load/store producers, one per ls tag
    bit lsPending [rsPkg::rsSize];
    logic [rsPkg::dataWidth-1:0] lsValue [rsPkg::rsSize];

    `include "aluRsRef.svh"

    aluRsTop UUT (
        .clk(clk),
        .rst(rst),
        .allocEn(allocEn),
        .allocOperandO(allocOperandO),
        .allocOperandT(allocOperandT),
        .allocTagO(allocTagO),
        .allocTagT(allocTagT),
        .allocTagW(allocTagW),
        .allocName(allocName),
        .allocOp(allocOp),
        .allocImm(allocImm),
        .lsValid(lsValid),
        .lsTag(lsTag),
        .lsData(lsData),
        .full(full),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .resultName(resultName),
        .resultData(resultData)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic failRun(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int randRange(input int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic logic [4:0] lsTagOf(input int k);
        return {rsPkg::unitLs, rsPkg::slotWidth'(k)};
    endfunction

    function automatic logic [4:0] aluTagOf(input int k);
        return {rsPkg::unitAlu, rsPkg::slotWidth'(k)};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #5;
        allocEn = 1'b0;
        lsValid = 1'b0;
    endtask

    // hand a produced value to every record waiting on its tag
    task automatic resolveTag(input logic [4:0] tag, input logic [31:0] value);
        for (int j = 0; j < rsPkg::rsSize; j++) begin
            if (busy[j] && waitO[j] == tag) begin
                valO[j] = value;
                waitO[j] = rsPkg::tagFree;
            end
            if (busy[j] && waitT[j] == tag) begin
                valT[j] = value;
                waitT[j] = rsPkg::tagFree;
            end
        end
    endtask

    task automatic allocate(input int slot, input logic [3:0] op,
                            input logic [31:0] vO, input logic [4:0] tO,
                            input logic [31:0] vT, input logic [4:0] tT);
        if (full) failRun("allocation attempted while full is high");
        if (busy[slot]) failRun($sformatf("allocation into busy slot %0d", slot));
        allocEn = 1'b1;
        allocTagW.fields.unit = rsPkg::unitAlu;
        allocTagW.fields.slot = rsPkg::slotWidth'(slot);
        allocOp = op;
        allocOperandO = vO;
        allocTagO.raw = tO;
        allocOperandT = vT;
        allocTagT.raw = tT;
        allocImm = $random(seed);
        allocName = rsPkg::nameWidth'($random(seed));
        expOp[slot] = op;
        valO[slot] = vO;
        waitO[slot] = tO;
        valT[slot] = vT;
        waitT[slot] = tT;
        expImm[slot] = allocImm;
        expName[slot] = allocName;
        allocCycle[slot] = cycleCount + 1;
        busy[slot] = 1'b1;
    endtask

    task automatic makeLs(input int k);
        lsPending[k] = 1'b1;
        lsValue[k] = $random(seed);
    endtask

    // call after any allocation of the same cycle
    task automatic lsBroadcast(input int k);
        lsValid = 1'b1;
        lsTag.raw = lsTagOf(k);
        lsData = lsValue[k];
        lsPending[k] = 1'b0;
        resolveTag(lsTagOf(k), lsValue[k]);
    endtask

    task automatic broadcastAnyLs();
        int start;
        start = randRange(rsPkg::rsSize);
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            if (lsPending[(start + i) % rsPkg::rsSize] && !lsValid) begin
                lsBroadcast((start + i) % rsPkg::rsSize);
            end
        end
    endtask

    // value, load/store tag or tag of a busy ALU slot
    task automatic pickOperand(output logic [31:0] val, output logic [4:0] tag);
        int mode;
        int k;
        mode = randRange(4);
        k = randRange(rsPkg::rsSize);
        val = $random(seed);
        tag = rsPkg::tagFree;
        if (mode == 2) begin
            if (!lsPending[k]) makeLs(k);
            tag = lsTagOf(k);
        end else if (mode == 3 && busy[k]) begin
            tag = aluTagOf(k);
        end
    endtask

    function automatic int freeSlot();
        int start;
        start = randRange(rsPkg::rsSize);
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            if (!busy[(start + i) % rsPkg::rsSize]) return (start + i) % rsPkg::rsSize;
        end
        return -1;
    endfunction

    function automatic bit anyBusy();
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            if (busy[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic waitResult(input int slot);
        int n;
        for (n = 0; n < 50 && busy[slot]; n++) nextCycle();
        if (busy[slot]) failRun($sformatf("timeout waiting for the result of slot %0d", slot));
    endtask

    task automatic waitDrain();
        int n;
        for (n = 0; n < 400 && anyBusy(); n++) begin
            broadcastAnyLs();
            nextCycle();
        end
        if (anyBusy()) failRun("timeout waiting for all slots to drain");
    endtask

    // scoreboard on the ALU broadcast
    always @(negedge clk) begin : monitor
        int slot;
        logic [31:0] expected;
        if (UUT.ctrl.props.failCount != 0) begin
            failRun("an assertion on the control block failed");
        end
        if (!rst && resultValid) begin
            slot = int'(resultTag.fields.slot);
            checkValue("resultTag.unit", resultTag.fields.unit, rsPkg::unitAlu);
            if (!busy[slot]) failRun($sformatf("result for idle slot %0d", slot));
            if (waitO[slot] != rsPkg::tagFree || waitT[slot] != rsPkg::tagFree) begin
                failRun($sformatf("slot %0d gave a result before its operands", slot));
            end
            expected = aluRef(expOp[slot], valO[slot], valT[slot], expImm[slot]);
            checkValue("resultData", resultData, expected);
            checkValue("resultName", resultName, expName[slot]);
            latency[slot] = cycleCount - allocCycle[slot];
            busy[slot] = 1'b0;
            resolveTag(aluTagOf(slot), expected);
        end
    end

    initial begin
        int order [8];
        int slot;
        int cyc;
        int allocCount;
        logic [31:0] vO;
        logic [31:0] vT;
        logic [4:0] tO;
        logic [4:0] tT;
        rst = 1'b1;
        allocEn = 1'b0;
        allocOperandO = '0;
        allocOperandT = '0;
        allocTagO = rsPkg::tagFree;
        allocTagT = rsPkg::tagFree;
        allocTagW = rsPkg::tagFree;
        allocName = rsPkg::nameFree;
        allocOp = rsPkg::opNop;
        allocImm = '0;
        lsValid = 1'b0;
        lsTag = rsPkg::tagFree;
        lsData = '0;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;

        // idle after reset
        checkValue("full", full, 1'b0);
        checkValue("resultValid", resultValid, 1'b0);
        repeat (5) nextCycle();

        // every op alone, operands ready at allocation
        for (int op = 1; op <= 9; op++) begin
            slot = (op - 1) % rsPkg::rsSize;
            allocate(slot, rsPkg::opWidth'(op), $random(seed), rsPkg::tagFree,
                     $random(seed), rsPkg::tagFree);
            waitResult(slot);
            checkValue("latency", latency[slot], 2);
        end

        // load/store operand, late broadcast
        makeLs(3);
        allocate(2, rsPkg::opSub, $random(seed), lsTagOf(3), $random(seed), rsPkg::tagFree);
        repeat (5) nextCycle();
        if (!busy[2]) failRun("result appeared before its load/store operand");
        lsBroadcast(3);
        waitResult(2);
        // broadcast in the cycle after allocation
        makeLs(5);
        allocate(4, rsPkg::opXor, $random(seed), rsPkg::tagFree, $random(seed), lsTagOf(5));
        nextCycle();
        lsBroadcast(5);
        waitResult(4);
        // broadcast in the allocation cycle itself
        makeLs(6);
        allocate(6, rsPkg::opAnd, $random(seed), lsTagOf(6), $random(seed), rsPkg::tagFree);
        lsBroadcast(6);
        waitResult(6);

        // dependency chain through the ALU feedback
        makeLs(1);
        allocate(0, rsPkg::opAdd, $random(seed), lsTagOf(1), $random(seed), rsPkg::tagFree);
        nextCycle();
        allocate(1, rsPkg::opSll, 0, aluTagOf(0), $random(seed), rsPkg::tagFree);
        nextCycle();
        allocate(2, rsPkg::opSub, 0, aluTagOf(1), 0, aluTagOf(0));
        nextCycle();
        allocate(3, rsPkg::opSlt, 0, aluTagOf(2), 0, aluTagOf(1));
        nextCycle();
        allocate(4, rsPkg::opAddImm, 0, aluTagOf(3), $random(seed), rsPkg::tagFree);
        nextCycle();
        lsBroadcast(1);
        nextCycle();
        waitDrain();

        // fill every slot behind load/store operands
        for (int i = 0; i < rsPkg::rsSize; i++) begin
            makeLs(i);
            allocate(i, rsPkg::opWidth'(randRange(9) + 1), $random(seed), lsTagOf(i),
                     $random(seed), rsPkg::tagFree);
            nextCycle();
        end
        checkValue("full", full, 1'b1);
        order = '{5, 2, 7, 0, 3, 6, 1, 4};
        lsBroadcast(order[0]);
        nextCycle();
        checkValue("full", full, 1'b0);
        for (int i = 1; i < 8; i++) begin
            lsBroadcast(order[i]);
            nextCycle();
        end
        waitDrain();

        // random mix
        allocCount = 0;
        for (cyc = 0; cyc < 20000 && allocCount < 300; cyc++) begin
            slot = freeSlot();
            if (!full && slot >= 0 && randRange(4) != 0) begin
                pickOperand(vO, tO);
                pickOperand(vT, tT);
                allocate(slot, rsPkg::opWidth'(randRange(9) + 1), vO, tO, vT, tT);
                allocCount++;
            end
            if (randRange(3) == 0) broadcastAnyLs();
            nextCycle();
        end
        if (allocCount < 300) failRun("timeout in the random phase");
        waitDrain();
        // a duplicate result would hit an idle slot here
        repeat (10) nextCycle();
        checkValue("full", full, 1'b0);

        if (UUT.ctrl.props.failCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d assertion failures", UUT.ctrl.props.failCount);
            $display("Result: FAILED");
            $fatal(1, "assertions failed");
        end
    end

endmodule

// File: sources.f
+incdir+verification
hdl/rsPkg.sv
hdl/rsEntry.sv
hdl/aluRsCtrl.sv
hdl/aluUnit.sv
hdl/aluRsTop.sv
verification/aluRsProperties.sv
verification/aluRsTb.sv
